//--- sim/ioCommandStim.txt
# In: ack op addr data dest wbReq taken ioAck reg mem ioDest ioData
# Exp: mask(b0 cmdReq b1 wbAck b2 wbDest/Data b3 ioEn b4 rr/ioDest/ioData b5 ioReq) then values
0 0 0000 0000 0 1 1 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1
0 0 0000 0000 0 1 1 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1
0 0 0000 0000 0 1 1 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1
1 4 0000 1234 0 1 1 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1
1 4 0001 abcd 0 1 1 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1
1 5 0001 abcd 3 1 1 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1
1 8 0000 0000 5 1 1 0 0 0 0 00000000 3b 1 0 0 0000 1 0 3 abcd1234 1
0 0 0000 0000 0 1 1 0 0 0 0 00000000 3b 1 0 0 0000 1 1 5 abcd1234 1
0 0 0000 0000 0 1 1 1 0 1 0 8f7e6a15 2b 1 0 0 0000 0 0 0 00000000 1
0 0 0000 0000 0 1 1 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1
1 0 0001 0000 6 1 1 0 0 0 0 00000000 2f 1 1 6 8f7e 0 0 0 00000000 1
1 1 0003 0000 7 1 1 0 0 0 0 00000000 2f 1 1 7 008f 0 0 0 00000000 1
1 3 0003 0000 8 1 1 0 0 0 0 00000000 2f 1 1 8 ff8f 0 0 0 00000000 1
1 3 0001 0000 9 1 1 0 0 0 0 00000000 2f 1 1 9 006a 0 0 0 00000000 1
0 0 0000 0000 0 1 1 1 1 0 a 1357c0de 2b 1 0 0 0000 0 0 0 00000000 1
1 0 0001 0000 b 0 1 0 0 0 0 00000000 2f 0 1 a c0de 0 0 0 00000000 1
1 0 0001 0000 b 0 1 0 0 0 0 00000000 2f 0 1 a c0de 0 0 0 00000000 1
1 0 0001 0000 b 1 1 0 0 0 0 00000000 2f 0 1 a c0de 0 0 0 00000000 1
1 0 0001 0000 b 1 1 0 0 0 0 00000000 2f 1 1 b 1357 0 0 0 00000000 1
1 5 0000 1111 1 1 0 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1
1 5 0000 2222 2 1 0 0 0 0 0 00000000 3b 1 0 0 0000 1 0 1 abcd1111 1
1 5 0000 3333 3 1 0 0 0 0 0 00000000 3b 1 0 0 0000 1 0 1 abcd1111 1
1 5 0000 4444 4 1 0 0 0 0 0 00000000 3b 1 0 0 0000 1 0 1 abcd1111 1
1 5 0000 5555 5 1 0 0 0 0 0 00000000 3b 0 0 0 0000 1 0 1 abcd1111 1
1 5 0000 5555 5 1 1 0 0 0 0 00000000 3b 0 0 0 0000 1 0 1 abcd1111 1
1 5 0000 5555 5 1 1 0 0 0 0 00000000 3b 1 0 0 0000 1 0 2 abcd2222 1
0 0 0000 0000 0 1 1 0 0 0 0 00000000 3b 1 0 0 0000 1 0 3 abcd3333 1
0 0 0000 0000 0 1 1 0 0 0 0 00000000 3b 1 0 0 0000 1 0 4 abcd4444 1
0 0 0000 0000 0 1 1 0 0 0 0 00000000 3b 1 0 0 0000 1 0 5 abcd5555 1
0 0 0000 0000 0 1 1 0 0 0 0 00000000 2b 1 0 0 0000 0 0 0 00000000 1

//--- tb.f
hdl/ioCmdPkg.sv
hdl/ioSyncFifo.sv
hdl/ioStoreBuffer.sv
hdl/ioCommandRouter.sv
hdl/ioResponseUnit.sv
hdl/ioLoadAlign.sv
hdl/ioWritebackArbiter.sv
hdl/ioCommandController.sv
sim/tbClockGen.sv
sim/ioCommandTb.sv

//--- sim/ioCommandTb.sv
// Testbench that replays a stimulus table on the IO command controller and checks its outputs
`timescale 1ns/10ps

module ioCommandTb;
    localparam string stimPath   = "sim/ioCommandStim.txt";
    localparam int    fieldCount = 22;
    localparam int    driveDelay = 1;
    localparam int    checkDelay = 2;

    logic               sys_clk;
    logic               rstN;
    logic               CommandACK;
    logic               CommandREQ;
    ioCmdPkg::minorOpT  MinorOpcodeIn;
    ioCmdPkg::dataWordT CommandAddressIn;
    ioCmdPkg::dataWordT CommandDataIn;
    ioCmdPkg::destRegT  CommandDestReg;
    logic               WritebackACK;
    logic               WritebackREQ;
    ioCmdPkg::destRegT  WritebackDestReg;
    ioCmdPkg::dataWordT WritebackDataOut;
    logic               IOCommandEn;
    logic               IOCommandTaken;
    logic               IOResponseRequested;
    ioCmdPkg::destRegT  IODestRegOut;
    ioCmdPkg::portWordT IODataOut;
    logic               IOACK;
    logic               IOREQ;
    logic               IORegResponseFlag;
    logic               IOMemResponseFlag;
    ioCmdPkg::destRegT  IODestRegIn;
    ioCmdPkg::portWordT IODataIn;

    // One parsed table line, inputs first and expectations after
    logic [31:0] fields [fieldCount];
    string       line;
    int          fd;
    int          stepCount;
    int          stepIdx;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    tbClockGen #(
        .HALFPERIOD (2),
        .RESETCYCLES(2)
    ) tbClockGen_inst (
        .sys_clk(sys_clk),
        .rstN   (rstN)
    );

    ioCommandController #(
        .FIFODEPTH(4),
        .PORTBYTES(4)
    ) ioCommandController_inst (
        .sys_clk            (sys_clk),
        .rstN               (rstN),
        .CommandACK         (CommandACK),
        .CommandREQ         (CommandREQ),
        .MinorOpcodeIn      (MinorOpcodeIn),
        .CommandAddressIn   (CommandAddressIn),
        .CommandDataIn      (CommandDataIn),
        .CommandDestReg     (CommandDestReg),
        .WritebackACK       (WritebackACK),
        .WritebackREQ       (WritebackREQ),
        .WritebackDestReg   (WritebackDestReg),
        .WritebackDataOut   (WritebackDataOut),
        .IOCommandEn        (IOCommandEn),
        .IOCommandTaken     (IOCommandTaken),
        .IOResponseRequested(IOResponseRequested),
        .IODestRegOut       (IODestRegOut),
        .IODataOut          (IODataOut),
        .IOACK              (IOACK),
        .IOREQ              (IOREQ),
        .IORegResponseFlag  (IORegResponseFlag),
        .IOMemResponseFlag  (IOMemResponseFlag),
        .IODestRegIn        (IODestRegIn),
        .IODataIn           (IODataIn)
    );

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // Field count of a data line, zero for comments and blank lines
    function automatic int parseLine(string text);
        int n;
        if (text.len() == 0 || text[0] == "#") begin
            return 0;
        end
        n = $sscanf(text,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
                    fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
                    fields[12], fields[13], fields[14], fields[15], fields[16],
                    fields[17], fields[18], fields[19], fields[20], fields[21]);
        return n;
    endfunction

    task automatic openStim();
        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            failRun({"Could not open the stimulus file ", stimPath});
        end
    endtask

    task automatic countSteps();
        int n;
        openStim();
        stepCount = 0;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                n = parseLine(line);
                if (n == fieldCount) begin
                    stepCount++;
                end else if (n > 0) begin
                    failRun($sformatf("Stimulus line after step %0d is incomplete", stepCount));
                end
            end
        end
        $fclose(fd);
        if (stepCount == 0) begin
            failRun("The stimulus file holds no steps");
        end
    endtask

    task automatic nextStep(output bit found);
        int n;
        found = 1'b0;
        while (!found && !$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                n = parseLine(line);
                found = (n == fieldCount);
            end
        end
    endtask

    task automatic driveInputs();
        CommandACK        = fields[0][0];
        MinorOpcodeIn     = fields[1][3:0];
        CommandAddressIn  = fields[2][15:0];
        CommandDataIn     = fields[3][15:0];
        CommandDestReg    = fields[4][3:0];
        WritebackREQ      = fields[5][0];
        IOCommandTaken    = fields[6][0];
        IOACK             = fields[7][0];
        IORegResponseFlag = fields[8][0];
        IOMemResponseFlag = fields[9][0];
        IODestRegIn       = fields[10][3:0];
        IODataIn          = fields[11];
    endtask

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            failRun($sformatf("[ERROR] step %0d %s expected 0x%0h actual 0x%0h",
                              stepIdx, name, expected, actual));
        end
    endtask

    // Mask bits pick which outputs this step checks
    task automatic checkOutputs();
        logic [5:0] mask;
        mask = fields[12][5:0];
        if (mask[0]) begin
            checkValue("CommandREQ", fields[13], CommandREQ);
        end
        if (mask[1]) begin
            checkValue("WritebackACK", fields[14], WritebackACK);
        end
        if (mask[2]) begin
            checkValue("WritebackDestReg", fields[15], WritebackDestReg);
            checkValue("WritebackDataOut", fields[16], WritebackDataOut);
        end
        if (mask[3]) begin
            checkValue("IOCommandEn", fields[17], IOCommandEn);
        end
        if (mask[4]) begin
            checkValue("IOResponseRequested", fields[18], IOResponseRequested);
            checkValue("IODestRegOut", fields[19], IODestRegOut);
            checkValue("IODataOut", fields[20], IODataOut);
        end
        if (mask[5]) begin
            checkValue("IOREQ", fields[21], IOREQ);
        end
    endtask

    always @(posedge sys_clk) begin
        cycleCount = cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            failRun($sformatf("Timeout after %0d cycles at step %0d", cycleCount, stepIdx));
        end
    end

    initial begin
        bit found;
        CommandACK        = 1'b0;
        MinorOpcodeIn     = '0;
        CommandAddressIn  = '0;
        CommandDataIn     = '0;
        CommandDestReg    = '0;
        WritebackREQ      = 1'b1;
        IOCommandTaken    = 1'b1;
        IOACK             = 1'b0;
        IORegResponseFlag = 1'b0;
        IOMemResponseFlag = 1'b0;
        IODestRegIn       = '0;
        IODataIn          = '0;
        stepIdx           = 0;
        countSteps();
        cycleLimit = stepCount + 20;
        openStim();
        nextStep(found);
        // Drive just after the edge, check just before the next one
        while (found) begin
            @(posedge sys_clk);
            #driveDelay;
            driveInputs();
            #checkDelay;
            checkOutputs();
            stepIdx++;
            nextStep(found);
        end
        $fclose(fd);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- sim/tbClockGen.sv
// Testbench clock and power-on reset generator for the IO command controller
`timescale 1ns/10ps

module tbClockGen #(
    parameter int HALFPERIOD  = 2,
    parameter int RESETCYCLES = 2
)(
    output logic sys_clk,
    output logic rstN
);
    initial begin
        sys_clk = 1'b0;
        forever #HALFPERIOD sys_clk = ~sys_clk;
    end

    // Release comes just after the last reset edge
    initial begin
        rstN = 1'b0;
        repeat (RESETCYCLES) @(posedge sys_clk);
        #1 rstN = 1'b1;
    end

endmodule

//--- hdl/ioCommandController.sv
// IO port command controller top level joining store, load and response paths
`timescale 1ns/10ps

module ioCommandController #(
    parameter int FIFODEPTH = 4,
    parameter int PORTBYTES = 4
)(
    input  logic               sys_clk,
    input  logic               rstN,
    input  logic               CommandACK,
    output logic               CommandREQ,
    input  ioCmdPkg::minorOpT  MinorOpcodeIn,
    input  ioCmdPkg::dataWordT CommandAddressIn,
    input  ioCmdPkg::dataWordT CommandDataIn,
    input  ioCmdPkg::destRegT  CommandDestReg,
    output logic               WritebackACK,
    input  logic               WritebackREQ,
    output ioCmdPkg::destRegT  WritebackDestReg,
    output ioCmdPkg::dataWordT WritebackDataOut,
    output logic               IOCommandEn,
    input  logic               IOCommandTaken,
    output logic               IOResponseRequested,
    output ioCmdPkg::destRegT  IODestRegOut,
    output ioCmdPkg::portWordT IODataOut,
    input  logic               IOACK,
    output logic               IOREQ,
    input  logic               IORegResponseFlag,
    input  logic               IOMemResponseFlag,
    input  ioCmdPkg::destRegT  IODestRegIn,
    input  ioCmdPkg::portWordT IODataIn
);
    logic                          storeAck;
    logic                          storeReq;
    logic                          commit;
    logic                          halfSel;
    ioCmdPkg::dataWordT            storeData;
    ioCmdPkg::portWordT            bufWord;
    logic                          pushAck;
    logic                          pushReq;
    logic [ioCmdPkg::cmdWordW-1:0] pushEntry;
    logic                          cmdFifoAck;
    logic                          cmdFifoReq;
    logic [ioCmdPkg::cmdWordW-1:0] cmdFifoData;
    logic [ioCmdPkg::cmdWordW-1:0] cmdHead;
    logic                          staleAck;
    logic                          staleGrant;
    logic                          rspAck;
    logic                          rspGrant;
    ioCmdPkg::destRegT             rspDest;
    ioCmdPkg::portWordT            rspData;
    ioCmdPkg::portWordT            loadBuffer;

    ioCommandRouter ioCommandRouter_inst (
        .CommandACK      (CommandACK),
        .CommandREQ      (CommandREQ),
        .MinorOpcodeIn   (MinorOpcodeIn),
        .CommandAddressIn(CommandAddressIn),
        .CommandDataIn   (CommandDataIn),
        .CommandDestReg  (CommandDestReg),
        .storeAck        (storeAck),
        .storeReq        (storeReq),
        .commit          (commit),
        .halfSel         (halfSel),
        .storeData       (storeData),
        .bufWord         (bufWord),
        .pushAck         (pushAck),
        .pushReq         (pushReq),
        .pushEntry       (pushEntry),
        .cmdFifoAck      (cmdFifoAck),
        .cmdFifoReq      (cmdFifoReq),
        .cmdFifoData     (cmdFifoData),
        .staleAck        (staleAck),
        .staleGrant      (staleGrant)
    );

    ioStoreBuffer #(
        .PORTBYTES(PORTBYTES)
    ) ioStoreBuffer_inst (
        .sys_clk  (sys_clk),
        .rstN     (rstN),
        .storeAck (storeAck),
        .storeReq (storeReq),
        .commit   (commit),
        .halfSel  (halfSel),
        .storeData(storeData),
        .storeDest(CommandDestReg),
        .bufWord  (bufWord),
        .pushAck  (pushAck),
        .pushReq  (pushReq),
        .pushEntry(pushEntry)
    );

    // Command queue toward the IO side
    ioSyncFifo #(
        .WIDTH(ioCmdPkg::cmdWordW),
        .DEPTH(FIFODEPTH)
    ) cmdFifo_inst (
        .sys_clk(sys_clk),
        .rstN   (rstN),
        .inAck  (cmdFifoAck),
        .inReq  (cmdFifoReq),
        .inData (cmdFifoData),
        .outAck (IOCommandEn),
        .outReq (IOCommandTaken),
        .outData(cmdHead)
    );

    assign IOResponseRequested = cmdHead[ioCmdPkg::cmdWordW-1];
    assign IODestRegOut        = cmdHead[ioCmdPkg::cmdWordW-2 -: ioCmdPkg::destRegW];
    assign IODataOut           = cmdHead[ioCmdPkg::portWordW-1:0];

    ioResponseUnit #(
        .FIFODEPTH(FIFODEPTH)
    ) ioResponseUnit_inst (
        .sys_clk          (sys_clk),
        .rstN             (rstN),
        .IOACK            (IOACK),
        .IOREQ            (IOREQ),
        .IORegResponseFlag(IORegResponseFlag),
        .IOMemResponseFlag(IOMemResponseFlag),
        .IODestRegIn      (IODestRegIn),
        .IODataIn         (IODataIn),
        .rspAck           (rspAck),
        .rspGrant         (rspGrant),
        .rspDest          (rspDest),
        .rspData          (rspData),
        .loadBuffer       (loadBuffer)
    );

    ioWritebackArbiter ioWritebackArbiter_inst (
        .rspAck          (rspAck),
        .rspGrant        (rspGrant),
        .rspDest         (rspDest),
        .rspData         (rspData),
        .staleAck        (staleAck),
        .staleGrant      (staleGrant),
        .staleDest       (CommandDestReg),
        .loadBuffer      (loadBuffer),
        .minorOp         (MinorOpcodeIn),
        .offset          (CommandAddressIn),
        .WritebackACK    (WritebackACK),
        .WritebackREQ    (WritebackREQ),
        .WritebackDestReg(WritebackDestReg),
        .WritebackDataOut(WritebackDataOut)
    );

endmodule

//--- hdl/ioWritebackArbiter.sv
// Writeback arbiter giving register responses priority over stale loads
`timescale 1ns/10ps

module ioWritebackArbiter (
    input  logic               rspAck,
    output logic               rspGrant,
    input  ioCmdPkg::destRegT  rspDest,
    input  ioCmdPkg::portWordT rspData,
    input  logic               staleAck,
    output logic               staleGrant,
    input  ioCmdPkg::destRegT  staleDest,
    input  ioCmdPkg::portWordT loadBuffer,
    input  ioCmdPkg::minorOpT  minorOp,
    input  ioCmdPkg::dataWordT offset,
    output logic               WritebackACK,
    input  logic               WritebackREQ,
    output ioCmdPkg::destRegT  WritebackDestReg,
    output ioCmdPkg::dataWordT WritebackDataOut
);
    ioCmdPkg::dataWordT staleData;

    ioLoadAlign #(
        .PORTBYTES($bits(ioCmdPkg::portWordT) / 8)
    ) loadAlign_inst (
        .loadBuffer (loadBuffer),
        .byteSel    (minorOp[ioCmdPkg::byteBit]),
        .signExt    (minorOp[ioCmdPkg::signExtBit]),
        .offset     (offset),
        .alignedData(staleData)
    );

    // Fixed priority, response at the queue head always wins
    assign rspGrant   = rspAck && WritebackREQ;
    assign staleGrant = WritebackREQ && !rspAck;

    always_comb begin
        if (rspAck) begin
            WritebackACK     = 1'b1;
            WritebackDestReg = rspDest;
            // Register responses write back the low data word
            WritebackDataOut = rspData[ioCmdPkg::dataWordW-1:0];
        end else begin
            WritebackACK     = staleAck;
            WritebackDestReg = staleDest;
            WritebackDataOut = staleData;
        end
    end

endmodule

//--- hdl/ioLoadAlign.sv
// Load aligner that picks a byte or halfword of the load buffer and extends it
`timescale 1ns/10ps

module ioLoadAlign #(
    parameter int PORTBYTES = 4
)(
    input  ioCmdPkg::portWordT loadBuffer,
    input  logic               byteSel,
    input  logic               signExt,
    input  ioCmdPkg::dataWordT offset,
    output ioCmdPkg::dataWordT alignedData
);
    localparam int idxW = $clog2(PORTBYTES);

    logic [PORTBYTES-1:0][7:0]                      bytes;
    ioCmdPkg::dataWordT [PORTBYTES/2-1:0]           halves;
    logic [7:0]                                     pickedByte;
    ioCmdPkg::dataWordT                             pickedHalf;

    assign bytes  = loadBuffer;
    assign halves = loadBuffer;

    // Halfwords are indexed by the low address bits like stores
    assign pickedByte = bytes[offset[idxW-1:0]];
    assign pickedHalf = halves[offset[idxW-2:0]];

    always_comb begin
        if (byteSel) begin
            alignedData = {{8{signExt && pickedByte[7]}}, pickedByte};
        end else begin
            // Halfword is already 16 bits wide
            alignedData = pickedHalf;
        end
    end

endmodule

//--- hdl/ioResponseUnit.sv
// Response queue with load buffer update and pop control for memory and register responses
`timescale 1ns/10ps

module ioResponseUnit #(
    parameter int FIFODEPTH = 4
)(
    input  logic               sys_clk,
    input  logic               rstN,
    input  logic               IOACK,
    output logic               IOREQ,
    input  logic               IORegResponseFlag,
    input  logic               IOMemResponseFlag,
    input  ioCmdPkg::destRegT  IODestRegIn,
    input  ioCmdPkg::portWordT IODataIn,
    output logic               rspAck,
    input  logic               rspGrant,
    output ioCmdPkg::destRegT  rspDest,
    output ioCmdPkg::portWordT rspData,
    output ioCmdPkg::portWordT loadBuffer
);
    logic                          rspPush;
    logic [ioCmdPkg::rspWordW-1:0] rspIn;
    logic [ioCmdPkg::rspWordW-1:0] rspHead;
    logic                          headValid;
    logic                          headIsReg;
    logic                          headPop;

    // Only flagged responses enter the queue
    assign rspPush = IOACK && (IORegResponseFlag || IOMemResponseFlag);
    assign rspIn   = {IORegResponseFlag, IODestRegIn, IODataIn};

    ioSyncFifo #(
        .WIDTH(ioCmdPkg::rspWordW),
        .DEPTH(FIFODEPTH)
    ) rspFifo_inst (
        .sys_clk(sys_clk),
        .rstN   (rstN),
        .inAck  (rspPush),
        .inReq  (IOREQ),
        .inData (rspIn),
        .outAck (headValid),
        .outReq (headPop),
        .outData(rspHead)
    );

    assign headIsReg = rspHead[ioCmdPkg::rspWordW-1];
    assign rspDest   = rspHead[ioCmdPkg::rspWordW-2 -: ioCmdPkg::destRegW];
    assign rspData   = rspHead[ioCmdPkg::portWordW-1:0];

    // Memory entries drain on their own, register entries wait for the writeback grant
    assign rspAck  = headValid && headIsReg;
    assign headPop = !headIsReg || rspGrant;

    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            loadBuffer <= '0;
        end else if (headValid && headPop) begin
            loadBuffer <= rspData;
        end
    end

endmodule

//--- hdl/ioCommandRouter.sv
// Command router that decodes the minor opcode and steers the core command handshake
`timescale 1ns/10ps

module ioCommandRouter (
    input  logic                          CommandACK,
    output logic                          CommandREQ,
    input  ioCmdPkg::minorOpT             MinorOpcodeIn,
    input  ioCmdPkg::dataWordT            CommandAddressIn,
    input  ioCmdPkg::dataWordT            CommandDataIn,
    input  ioCmdPkg::destRegT             CommandDestReg,
    output logic                          storeAck,
    input  logic                          storeReq,
    output logic                          commit,
    output logic                          halfSel,
    output ioCmdPkg::dataWordT            storeData,
    input  ioCmdPkg::portWordT            bufWord,
    input  logic                          pushAck,
    output logic                          pushReq,
    input  logic [ioCmdPkg::cmdWordW-1:0] pushEntry,
    output logic                          cmdFifoAck,
    input  logic                          cmdFifoReq,
    output logic [ioCmdPkg::cmdWordW-1:0] cmdFifoData,
    output logic                          staleAck,
    input  logic                          staleGrant
);
    logic isStore;
    logic isLoadReq;
    logic isStale;

    assign isStore   = MinorOpcodeIn[ioCmdPkg::storeBit];
    assign isLoadReq = !isStore && MinorOpcodeIn[ioCmdPkg::loadReqBit];
    assign isStale   = !isStore && !MinorOpcodeIn[ioCmdPkg::loadReqBit];

    // Store path
    assign storeAck  = CommandACK && isStore;
    assign commit    = MinorOpcodeIn[ioCmdPkg::commitBit];
    assign halfSel   = CommandAddressIn[0];
    assign storeData = CommandDataIn;

    // Command FIFO input, commit entry or requesting load carrying the buffer word
    assign pushReq     = cmdFifoReq;
    assign cmdFifoAck  = isLoadReq ? CommandACK : pushAck;
    assign cmdFifoData = isLoadReq ? {1'b1, CommandDestReg, bufWord} : pushEntry;

    // Stale loads go to the writeback arbiter
    assign staleAck = CommandACK && isStale;

    always_comb begin
        if (isStore) begin
            CommandREQ = storeReq;
        end else if (isLoadReq) begin
            CommandREQ = cmdFifoReq;
        end else begin
            CommandREQ = staleGrant;
        end
    end

endmodule

//--- hdl/ioStoreBuffer.sv
// Store buffer that packs halfword stores into a port word and pushes it on commit
`timescale 1ns/10ps

module ioStoreBuffer #(
    parameter int PORTBYTES = 4
)(
    input  logic                         sys_clk,
    input  logic                         rstN,
    input  logic                         storeAck,
    output logic                         storeReq,
    input  logic                         commit,
    input  logic                         halfSel,
    input  ioCmdPkg::dataWordT           storeData,
    input  ioCmdPkg::destRegT            storeDest,
    output ioCmdPkg::portWordT           bufWord,
    output logic                         pushAck,
    input  logic                         pushReq,
    output logic [ioCmdPkg::cmdWordW-1:0] pushEntry
);
    localparam int halfCount = PORTBYTES / 2;

    ioCmdPkg::dataWordT [halfCount-1:0] halves;
    ioCmdPkg::dataWordT [halfCount-1:0] merged;
    logic                               storeTaken;

    // Word as it will look once this store lands
    always_comb begin
        merged          = halves;
        merged[halfSel] = storeData;
    end

    assign bufWord = halves;

    // A commit goes straight to the command FIFO in the cycle it is accepted,
    // so it waits at the core side while the FIFO is full
    assign pushAck   = storeAck && commit;
    assign pushEntry = {1'b0, storeDest, merged};
    assign storeReq  = commit ? pushReq : 1'b1;

    assign storeTaken = storeAck && storeReq;

    // Contents persist after a commit
    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            halves <= '0;
        end else if (storeTaken) begin
            halves <= merged;
        end
    end

endmodule

//--- hdl/ioSyncFifo.sv
// Synchronous FIFO with ACK/REQ handshakes on the write and read sides
`timescale 1ns/10ps

module ioSyncFifo #(
    parameter int WIDTH = 37,
    parameter int DEPTH = 4
)(
    input  logic             sys_clk,
    input  logic             rstN,
    input  logic             inAck,
    output logic             inReq,
    input  logic [WIDTH-1:0] inData,
    output logic             outAck,
    input  logic             outReq,
    output logic [WIDTH-1:0] outData
);
    localparam int ptrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cntW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [cntW-1:0]  count;
    logic             push;
    logic             pop;

    assign inReq   = (count != cntW'(DEPTH));
    assign outAck  = (count != '0);
    assign push    = inAck && inReq;
    assign pop     = outAck && outReq;
    assign outData = mem[rdPtr];

    always_ff @(posedge sys_clk) begin
        if (push) begin
            mem[wrPtr] <= inData;
        end
    end

    // Pointers wrap explicitly so any depth works
    always_ff @(posedge sys_clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/ioCmdPkg.sv
// IO command controller shared widths, types and minor-opcode field positions
package ioCmdPkg;

    localparam int dataWordW = 16;
    localparam int portWordW = 32;
    localparam int destRegW  = 4;
    localparam int minorOpW  = 4;

    typedef logic [dataWordW-1:0] dataWordT;
    typedef logic [portWordW-1:0] portWordT;
    typedef logic [destRegW-1:0]  destRegT;
    typedef logic [minorOpW-1:0]  minorOpT;

    // Minor opcode fields
    localparam int loadReqBit = 3;
    localparam int storeBit   = 2;
    localparam int signExtBit = 1;
    // Bit 0 is commit on stores and byte select on loads
    localparam int commitBit  = 0;
    localparam int byteBit    = 0;

    // Command entry is {responseRequested, destReg, portWord}
    localparam int cmdWordW = 1 + destRegW + portWordW;
    // Response entry is {regResponse, destReg, portWord}
    localparam int rspWordW = 1 + destRegW + portWordW;

endpackage
